//--- rv32i_isa_pkg.sv
package rv32i_isa_pkg;

    // One machine word, used for every data path in the stage
    localparam int XLEN = 32;

    // Major opcodes of the instruction classes handled here
    localparam logic [6:0] OP_REG    = 7'b0110011;
    localparam logic [6:0] OP_IMM    = 7'b0010011;
    localparam logic [6:0] OP_LUI    = 7'b0110111;
    localparam logic [6:0] OP_AUIPC  = 7'b0010111;
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;

    // Funct3 values of the register and immediate ALU operations
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_SLTU    = 3'b011;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SRL_SRA = 3'b101;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    // Funct3 values of the conditional branches
    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

    // Instruction bit that is funct7 bit 5, it picks SUB and SRA
    localparam int F7_ALT_BIT = 30;

    // The ALU control code is the branch field on top of the operation nibble
    localparam int ALU_OP_W  = 4;
    localparam int ALU_BR_W  = 3;
    localparam int ALU_CTL_W = ALU_BR_W + ALU_OP_W;

    // Operation codes in the low nibble of the control code
    localparam logic [ALU_OP_W-1:0] ALU_AND  = 4'b0000;
    localparam logic [ALU_OP_W-1:0] ALU_OR   = 4'b0001;
    localparam logic [ALU_OP_W-1:0] ALU_ADD  = 4'b0010;
    localparam logic [ALU_OP_W-1:0] ALU_SRL  = 4'b0011;
    localparam logic [ALU_OP_W-1:0] ALU_SRA  = 4'b0100;
    localparam logic [ALU_OP_W-1:0] ALU_SLL  = 4'b0101;
    localparam logic [ALU_OP_W-1:0] ALU_SUB  = 4'b0110;
    localparam logic [ALU_OP_W-1:0] ALU_SLT  = 4'b0111;
    localparam logic [ALU_OP_W-1:0] ALU_XOR  = 4'b1000;
    localparam logic [ALU_OP_W-1:0] ALU_SLTU = 4'b1001;
    // Not decoded by the ALU, so the result comes out as zero
    localparam logic [ALU_OP_W-1:0] ALU_ZERO = 4'b1111;

    // Branch compare codes in the high three bits
    localparam logic [ALU_BR_W-1:0] BR_NONE = 3'b000;
    localparam logic [ALU_BR_W-1:0] BR_BEQ  = 3'b001;
    localparam logic [ALU_BR_W-1:0] BR_BNE  = 3'b010;
    localparam logic [ALU_BR_W-1:0] BR_BLT  = 3'b011;
    localparam logic [ALU_BR_W-1:0] BR_BGE  = 3'b100;
    localparam logic [ALU_BR_W-1:0] BR_BLTU = 3'b101;
    localparam logic [ALU_BR_W-1:0] BR_BGEU = 3'b110;

endpackage

//--- exec_pkg.sv
package exec_pkg;

    // Word width and control code width come from the ISA package
    import rv32i_isa_pkg::*;

    // Step to the next sequential instruction
    localparam logic [XLEN-1:0] PC_STEP = 32'd4;

    // Packet handed over by the issue stage, one instruction at a time
    typedef struct packed {
        // Raw instruction word
        logic [XLEN-1:0] instr;
        // Address of the instruction
        logic [XLEN-1:0] pc;
        // Source register values, already read by the issue stage
        logic [XLEN-1:0] rs1_val;
        logic [XLEN-1:0] rs2_val;
    } exec_req_t;

    // Decoded operand bundle between decode, ALU and result former
    typedef struct packed {
        // Branch field in the top bits, operation nibble below
        logic [ALU_CTL_W-1:0] ctl;
        logic [XLEN-1:0]      operand_a;
        logic [XLEN-1:0]      operand_b;
        // Sign extended B-type offset, only meaningful for branches
        logic [XLEN-1:0]      br_offset;
        logic [XLEN-1:0]      pc;
    } alu_op_t;

    // Packet handed downstream once the instruction has executed
    typedef struct packed {
        // ALU result, load/store address or LUI value, zero for branches
        logic [XLEN-1:0] rd_val;
        logic [XLEN-1:0] next_pc;
        logic            taken;
    } exec_rsp_t;

endpackage

//--- hs_slot.sv
`timescale 1ns/1ns

module hs_slot #(
    parameter type payload_t = logic [31:0]
) (
    input  logic     clk_i,
    input  logic     rst_n_i,
    // Upstream side, this slot is the receiver
    input  logic     req_i,
    input  payload_t data_i,
    output logic     ack_o,
    // Downstream side, this slot is the sender
    output logic     req_o,
    output payload_t data_o,
    input  logic     ack_i
);

    logic     full_q;
    logic     ack_q;
    logic     req_q;
    payload_t data_q;
    logic     capture;

    // Take a new payload only when empty and the previous upstream cycle has closed
    assign capture = req_i && !ack_q && !full_q;

    // Upstream ack rises with the capture and falls once req_i is seen low
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ack_q <= 1'b0;
        end else if (capture) begin
            ack_q <= 1'b1;
        end else if (ack_q && !req_i) begin
            ack_q <= 1'b0;
        end
    end

    // Held payload, cleared at reset so the outputs start at zero
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            data_q <= '0;
        end else if (capture) begin
            data_q <= data_i;
        end
    end

    // Downstream req goes up on the capture edge and drops when ack_i is seen
    // The slot stays full until ack_i has returned low, which closes the cycle
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            full_q <= 1'b0;
            req_q  <= 1'b0;
        end else if (capture) begin
            full_q <= 1'b1;
            req_q  <= 1'b1;
        end else begin
            if (req_q && ack_i) begin
                req_q <= 1'b0;
            end
            if (full_q && !req_q && !ack_i) begin
                full_q <= 1'b0;
            end
        end
    end

    assign ack_o  = ack_q;
    assign req_o  = req_q;
    assign data_o = data_q;

endmodule

//--- alu_ctl_decode.sv
`timescale 1ns/1ns

module alu_ctl_decode
    import rv32i_isa_pkg::*;
    import exec_pkg::*;
(
    input  exec_req_t pkt_i,
    output alu_op_t   op_o
);

    logic [6:0]          opcode;
    logic [2:0]          funct3;
    logic                alt;
    logic [XLEN-1:0]     imm_i;
    logic [XLEN-1:0]     imm_s;
    logic [XLEN-1:0]     imm_u;
    logic [XLEN-1:0]     imm_b;
    logic [ALU_OP_W-1:0] alu_op;
    logic [ALU_BR_W-1:0] br_code;
    logic [XLEN-1:0]     opa;
    logic [XLEN-1:0]     opb;

    // Shared funct3 mapping of the R-type and I-type ALU groups
    // Only the register form can select SUB, both forms can select SRA
    function automatic logic [ALU_OP_W-1:0] arith_op(input logic [2:0] f3,
                                                     input logic       alt_bit,
                                                     input logic       is_reg);
        logic [ALU_OP_W-1:0] code;
        case (f3)
            F3_ADD_SUB: code = (is_reg && alt_bit) ? ALU_SUB : ALU_ADD;
            F3_SLL:     code = ALU_SLL;
            F3_SLT:     code = ALU_SLT;
            F3_SLTU:    code = ALU_SLTU;
            F3_XOR:     code = ALU_XOR;
            F3_SRL_SRA: code = alt_bit ? ALU_SRA : ALU_SRL;
            F3_OR:      code = ALU_OR;
            F3_AND:     code = ALU_AND;
            default:    code = ALU_ZERO;
        endcase
        return code;
    endfunction

    assign opcode = pkt_i.instr[6:0];
    assign funct3 = pkt_i.instr[14:12];
    assign alt    = pkt_i.instr[F7_ALT_BIT];

    // Immediates of the I, S, U and B formats, sign extended from bit 31
    assign imm_i = {{20{pkt_i.instr[31]}}, pkt_i.instr[31:20]};
    assign imm_s = {{20{pkt_i.instr[31]}}, pkt_i.instr[31:25], pkt_i.instr[11:7]};
    assign imm_u = {pkt_i.instr[31:12], 12'b0};
    assign imm_b = {{19{pkt_i.instr[31]}}, pkt_i.instr[31], pkt_i.instr[7],
                    pkt_i.instr[30:25], pkt_i.instr[11:8], 1'b0};

    always_comb begin
        // Unknown opcodes fall through to a zero result with no branch
        alu_op  = ALU_ZERO;
        br_code = BR_NONE;
        opa     = pkt_i.rs1_val;
        opb     = pkt_i.rs2_val;
        case (opcode)
            OP_REG: begin
                alu_op = arith_op(funct3, alt, 1'b1);
            end
            OP_IMM: begin
                // The shift amount sits in the low five bits of imm_i
                alu_op = arith_op(funct3, alt, 1'b0);
                opb    = imm_i;
            end
            OP_LUI: begin
                // AND with all ones passes the U immediate through
                alu_op = ALU_AND;
                opa    = '1;
                opb    = imm_u;
            end
            OP_AUIPC: begin
                alu_op = ALU_ADD;
                opa    = pkt_i.pc;
                opb    = imm_u;
            end
            OP_LOAD: begin
                alu_op = ALU_ADD;
                opb    = imm_i;
            end
            OP_STORE: begin
                alu_op = ALU_ADD;
                opb    = imm_s;
            end
            OP_BRANCH: begin
                // The compare works on rs1 minus rs2
                alu_op = ALU_SUB;
                case (funct3)
                    F3_BEQ:  br_code = BR_BEQ;
                    F3_BNE:  br_code = BR_BNE;
                    F3_BLT:  br_code = BR_BLT;
                    F3_BGE:  br_code = BR_BGE;
                    F3_BLTU: br_code = BR_BLTU;
                    F3_BGEU: br_code = BR_BGEU;
                    // Reserved branch encodings are treated like unknown opcodes
                    default: alu_op  = ALU_ZERO;
                endcase
            end
            default: begin
                alu_op = ALU_ZERO;
            end
        endcase
    end

    assign op_o.ctl       = {br_code, alu_op};
    assign op_o.operand_a = opa;
    assign op_o.operand_b = opb;
    assign op_o.br_offset = imm_b;
    assign op_o.pc        = pkt_i.pc;

endmodule

//--- alu.sv
`timescale 1ns/1ns

module alu
    import rv32i_isa_pkg::*;
(
    input  logic [XLEN-1:0]      a_i,
    input  logic [XLEN-1:0]      b_i,
    input  logic [ALU_CTL_W-1:0] sel_i,
    output logic [XLEN-1:0]      result_o,
    output logic                 branch_ena_o
);

    logic [ALU_OP_W-1:0] op_sel;
    logic [ALU_BR_W-1:0] br_sel;
    logic [4:0]          shamt;

    assign op_sel = sel_i[ALU_OP_W-1:0];
    assign br_sel = sel_i[ALU_CTL_W-1:ALU_OP_W];

    // Shifts only ever use the low five bits of the second operand
    assign shamt = b_i[4:0];

    // Low nibble picks the operation, several instruction forms share each code
    always_comb begin
        case (op_sel)
            // AND also covers ANDI and LUI
            ALU_AND:  result_o = a_i & b_i;
            ALU_OR:   result_o = a_i | b_i;
            // ADD also serves ADDI, AUIPC and every load and store address
            ALU_ADD:  result_o = a_i + b_i;
            // SUB is also the difference the branches compare against zero
            ALU_SUB:  result_o = a_i - b_i;
            ALU_SLT:  result_o = ($signed(a_i) < $signed(b_i)) ? 32'd1 : 32'd0;
            ALU_SLTU: result_o = (a_i < b_i) ? 32'd1 : 32'd0;
            ALU_SRL:  result_o = a_i >> shamt;
            // Arithmetic shift keeps the sign of a_i
            ALU_SRA:  result_o = $signed(a_i) >>> shamt;
            ALU_SLL:  result_o = a_i << shamt;
            ALU_XOR:  result_o = a_i ^ b_i;
            // Unused codes, including the decoder's zero code
            default:  result_o = '0;
        endcase
    end

    // High bits pick the branch compare
    // Equality reuses the result of the subtraction
    always_comb begin
        case (br_sel)
            BR_BEQ:  branch_ena_o = (result_o == '0);
            BR_BNE:  branch_ena_o = (result_o != '0);
            BR_BLT:  branch_ena_o = ($signed(a_i) < $signed(b_i));
            BR_BGE:  branch_ena_o = ($signed(a_i) >= $signed(b_i));
            BR_BLTU: branch_ena_o = (a_i < b_i);
            BR_BGEU: branch_ena_o = (a_i >= b_i);
            default: branch_ena_o = 1'b0;
        endcase
    end

endmodule

//--- exec_result.sv
`timescale 1ns/1ns

module exec_result
    import rv32i_isa_pkg::*;
    import exec_pkg::*;
(
    input  alu_op_t         op_i,
    input  logic [XLEN-1:0] alu_result_i,
    input  logic            branch_ena_i,
    output exec_rsp_t       rsp_o
);

    logic [ALU_BR_W-1:0] br_field;
    logic                is_branch;
    logic [XLEN-1:0]     seq_pc;
    logic [XLEN-1:0]     target_pc;

    // A valid branch is the only thing that sets the branch field
    assign br_field  = op_i.ctl[ALU_CTL_W-1:ALU_OP_W];
    assign is_branch = (br_field != BR_NONE);

    // Both candidate next pcs are formed, the compare outcome picks one
    assign seq_pc    = op_i.pc + PC_STEP;
    assign target_pc = op_i.pc + op_i.br_offset;

    // Branches write no register, so their rd value is forced to zero
    assign rsp_o.rd_val  = is_branch ? '0 : alu_result_i;
    assign rsp_o.taken   = branch_ena_i;
    assign rsp_o.next_pc = branch_ena_i ? target_pc : seq_pc;

endmodule

//--- exec_unit.sv
`timescale 1ns/1ns

module exec_unit
    import rv32i_isa_pkg::*;
    import exec_pkg::*;
(
    input  logic      clk_i,
    input  logic      rst_n_i,
    // Request side from the issue stage
    input  logic      in_req_i,
    input  exec_req_t in_pkt_i,
    output logic      in_ack_o,
    // Result side to the next stage
    output logic      out_req_o,
    output exec_rsp_t out_rsp_o,
    input  logic      out_ack_i
);

    logic            mid_req;
    logic            mid_ack;
    exec_req_t       held_pkt;
    alu_op_t         dec_op;
    logic [XLEN-1:0] alu_result;
    logic            alu_branch_ena;
    exec_rsp_t       next_rsp;

    // Input slot holds the request packet for the whole execute path
    hs_slot #(.payload_t(exec_req_t)) slot_in (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .req_i   (in_req_i),
        .data_i  (in_pkt_i),
        .ack_o   (in_ack_o),
        .req_o   (mid_req),
        .data_o  (held_pkt),
        .ack_i   (mid_ack)
    );

    // Decode, ALU and result former settle within the cycle after capture
    alu_ctl_decode decode_inst (
        .pkt_i (held_pkt),
        .op_o  (dec_op)
    );

    alu alu_inst (
        .a_i          (dec_op.operand_a),
        .b_i          (dec_op.operand_b),
        .sel_i        (dec_op.ctl),
        .result_o     (alu_result),
        .branch_ena_o (alu_branch_ena)
    );

    exec_result result_inst (
        .op_i         (dec_op),
        .alu_result_i (alu_result),
        .branch_ena_i (alu_branch_ena),
        .rsp_o        (next_rsp)
    );

    // Output slot captures the finished result and frees the input slot
    hs_slot #(.payload_t(exec_rsp_t)) slot_out (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .req_i   (mid_req),
        .data_i  (next_rsp),
        .ack_o   (mid_ack),
        .req_o   (out_req_o),
        .data_o  (out_rsp_o),
        .ack_i   (out_ack_i)
    );

endmodule

//--- tb_exec_checks.svh
`ifndef TB_EXEC_CHECKS_SVH
`define TB_EXEC_CHECKS_SVH

// Both random streams of the testbench start from this state
localparam logic [15:0] LFSR_SEED = 16'd90;

// One step of a 16-bit Galois LFSR with taps at 16, 14, 13 and 11
// The caller takes bit 0 of the returned state as its random bit
function automatic logic [15:0] lfsr_next(input logic [15:0] state);
    return state[0] ? ((state >> 1) ^ 16'hB400) : (state >> 1);
endfunction

// Compares a whole result packet and reports every field on a mismatch
task automatic check_rsp(input string     what,
                         input exec_rsp_t got,
                         input exec_rsp_t exp);
    if (got !== exp) begin
        $display("MISMATCH at %0t ns, %s, rd_val %h/%h next_pc %h/%h taken %b/%b (got/exp)",
                 $time, what, got.rd_val, exp.rd_val, got.next_pc, exp.next_pc,
                 got.taken, exp.taken);
        stop_on_error();
    end
endtask

// Compares one handshake level against the level the four-phase rule allows
task automatic check_handshake(input string what,
                               input logic  got,
                               input logic  exp);
    if (got !== exp) begin
        $display("MISMATCH at %0t ns, %s, got %b expected %b", $time, what, got, exp);
        stop_on_error();
    end
endtask

`endif

//--- tb_exec_unit.sv
`timescale 1ns/1ns

module tb_exec_unit
    import rv32i_isa_pkg::*;
    import exec_pkg::*;
();

    // Each vector is seven hex words in the order instr, pc, rs1, rs2, rd_val, next_pc, taken
    localparam int NUM_VEC     = 36;
    localparam int STIM_COLS   = 7;
    localparam int RESET_CYC   = 16;
    localparam int CLK_NS      = 4;
    // Generous budget of 40 cycles per vector on top of the reset time
    localparam int WATCHDOG_NS = (NUM_VEC * 40 + RESET_CYC) * CLK_NS;

    logic            clk;
    logic            rst_n;
    logic            in_req;
    exec_req_t       in_pkt;
    logic            in_ack;
    logic            out_req;
    exec_rsp_t       out_rsp;
    logic            out_ack;
    logic [XLEN-1:0] stim_mem [NUM_VEC*STIM_COLS];
    logic [15:0]     drv_lfsr  = 16'd0;
    logic [15:0]     acc_lfsr  = 16'd0;
    // Levels seen on the previous rising edge, for the protocol monitor
    logic            in_req_q  = 1'b0;
    logic            in_ack_q  = 1'b0;
    logic            out_req_q = 1'b0;
    exec_rsp_t       out_rsp_q = '0;
    int              rsp_count = 0;

    // Every failure path ends here
    task automatic stop_on_error();
        $display("RESULT: FAIL");
        $fatal(1, "stopped at the first error");
    endtask

    `include "tb_exec_checks.svh"

    // Request packet and expected result of one vector
    function automatic exec_req_t stim_req(input int v);
        return {stim_mem[v*STIM_COLS], stim_mem[v*STIM_COLS+1],
                stim_mem[v*STIM_COLS+2], stim_mem[v*STIM_COLS+3]};
    endfunction

    function automatic exec_rsp_t stim_rsp(input int v);
        return {stim_mem[v*STIM_COLS+4], stim_mem[v*STIM_COLS+5], stim_mem[v*STIM_COLS+6][0]};
    endfunction

    exec_unit exec_unit_inst (
        .clk_i     (clk),
        .rst_n_i   (rst_n),
        .in_req_i  (in_req),
        .in_pkt_i  (in_pkt),
        .in_ack_o  (in_ack),
        .out_req_o (out_req),
        .out_rsp_o (out_rsp),
        .out_ack_i (out_ack)
    );

    always #(CLK_NS / 2) clk = ~clk;

    // Issue side, one four-phase cycle per vector after a random gap of 0 to 3 cycles
    task automatic drive_requests();
        logic [1:0] gap;
        for (int i = 0; i < NUM_VEC; i++) begin
            gap = '0;
            for (int b = 0; b < 2; b++) begin
                drv_lfsr = lfsr_next(drv_lfsr);
                gap      = {gap[0], drv_lfsr[0]};
            end
            repeat (gap) @(posedge clk);
            in_pkt <= stim_req(i);
            in_req <= 1'b1;
            @(posedge clk);
            while (!in_ack) @(posedge clk);
            in_req <= 1'b0;
            // A new request may only go up once the ack has fallen
            @(posedge clk);
            while (in_ack) @(posedge clk);
        end
    endtask

    // Result side, answers each request after a random 0 to 7 cycles of back-pressure
    task automatic accept_results();
        logic [2:0] delay;
        for (int k = 0; k < NUM_VEC; k++) begin
            while (!out_req) @(posedge clk);
            check_rsp($sformatf("vector %0d result", k), out_rsp, stim_rsp(k));
            delay = '0;
            for (int b = 0; b < 3; b++) begin
                acc_lfsr = lfsr_next(acc_lfsr);
                delay    = {delay[1:0], acc_lfsr[0]};
            end
            repeat (delay) @(posedge clk);
            out_ack <= 1'b1;
            @(posedge clk);
            while (out_req) @(posedge clk);
            out_ack <= 1'b0;
            @(posedge clk);
        end
    endtask

    // Protocol monitor on the levels just before each rising edge
    always @(posedge clk) begin
        if (rst_n) begin
            // The input ack can only rise on an edge that saw the request high
            if (in_ack && !in_ack_q) begin
                check_handshake("in_req_i under a rising in_ack_o", in_req_q, 1'b1);
            end
            if (out_req && out_req_q) begin
                check_rsp("out_rsp_o held under out_req_o", out_rsp, out_rsp_q);
            end
            // Each rising out_req_o is one result handed downstream
            if (out_req && !out_req_q) begin
                rsp_count <= rsp_count + 1;
            end
        end
        in_req_q  <= in_req;
        in_ack_q  <= in_ack;
        out_req_q <= out_req;
        out_rsp_q <= out_rsp;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout, the test did not finish within %0d ns", WATCHDOG_NS);
        stop_on_error();
    end

    initial begin
        clk      = 1'b0;
        rst_n    = 1'b0;
        in_req   = 1'b0;
        in_pkt   = '0;
        out_ack  = 1'b0;
        drv_lfsr = LFSR_SEED;
        acc_lfsr = LFSR_SEED;
        // Fill first so that a short file leaves a taken column other than 0 or 1
        for (int a = 0; a < NUM_VEC * STIM_COLS; a++) begin
            stim_mem[a] = {16'hA5A5, a[15:0]};
        end
        $readmemh("exec_stim.txt", stim_mem);
        for (int v = 0; v < NUM_VEC; v++) begin
            if (stim_mem[v*STIM_COLS+6] > 32'd1) begin
                $display("Stimulus file exec_stim.txt is missing or has too few vectors");
                stop_on_error();
            end
        end
        repeat (RESET_CYC) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
        check_handshake("in_ack_o after reset", in_ack, 1'b0);
        check_handshake("out_req_o after reset", out_req, 1'b0);
        check_rsp("out_rsp_o after reset", out_rsp, '0);
        fork
            drive_requests();
            accept_results();
        join
        // Quiet period in which a duplicated result would show up
        repeat (20) @(posedge clk);
        if (rsp_count != NUM_VEC) begin
            $display("MISMATCH at %0t ns, %0d results seen for %0d vectors",
                     $time, rsp_count, NUM_VEC);
            stop_on_error();
        end else begin
            $display("RESULT: PASS");
            $finish;
        end
    end

endmodule

//--- exec_stim.txt
// Columns in hex: instr pc rs1 rs2 expected_rd_val expected_next_pc expected_taken
// R-type, I-type, LUI/AUIPC/load/store, six branches taken and not taken, one unknown opcode
003100b3 00000100 7fffffff 00000001 80000000 00000104 0
403100b3 00000104 00000000 00000001 ffffffff 00000108 0
003110b3 00000108 00000003 00000024 00000030 0000010c 0
003120b3 0000010c ffffffff 00000001 00000001 00000110 0
003130b3 00000110 ffffffff 00000001 00000000 00000114 0
003140b3 00000114 aaaa5555 ffff0000 55555555 00000118 0
003150b3 00000118 80000000 0000001f 00000001 0000011c 0
403150b3 0000011c 80000000 00000004 f8000000 00000120 0
003160b3 00000120 0f0f0000 000000f0 0f0f00f0 00000124 0
003170b3 00000124 ff00ff00 0ff00ff0 0f000f00 00000128 0
fff10093 00000128 00000005 deadbeef 00000004 0000012c 0
fff12093 0000012c 80000000 deadbeef 00000001 00000130 0
fff13093 00000130 00000005 deadbeef 00000001 00000134 0
7ff14093 00000134 12345678 deadbeef 12345187 00000138 0
0f016093 00000138 00000f00 deadbeef 00000ff0 0000013c 0
0ff17093 0000013c 12345678 deadbeef 00000078 00000140 0
01f11093 00000140 00000001 deadbeef 80000000 00000144 0
00415093 00000144 f0000000 deadbeef 0f000000 00000148 0
41f15093 00000148 80000000 deadbeef ffffffff 0000014c 0
123450b7 00000200 00000000 00000000 12345000 00000204 0
00001097 00000204 00000000 00000000 00001204 00000208 0
ffc12083 00000208 00001000 00000000 00000ffc 0000020c 0
00312823 0000020c 00002000 55555555 00002010 00000210 0
00310863 00000300 12345678 12345678 00000000 00000310 1
00310863 00000304 00000001 00000002 00000000 00000308 0
fe311ce3 00000308 00000001 00000002 00000000 00000300 1
fe311ce3 0000030c 00000005 00000005 00000000 00000310 0
00314863 00000310 80000000 7fffffff 00000000 00000320 1
00314863 00000314 7fffffff 80000000 00000000 00000318 0
fe315ce3 00000318 ffffffff ffffffff 00000000 00000310 1
fe315ce3 0000031c ffffffff 00000000 00000000 00000320 0
00316863 00000320 00000000 ffffffff 00000000 00000330 1
00316863 00000324 80000000 7fffffff 00000000 00000328 0
fe317ce3 00000328 80000000 7fffffff 00000000 00000320 1
fe317ce3 0000032c 00000000 00000001 00000000 00000330 0
0040006f 00000400 11111111 22222222 00000000 00000404 0

//--- src.f
+incdir+.
rv32i_isa_pkg.sv
exec_pkg.sv
hs_slot.sv
alu_ctl_decode.sv
alu.sv
exec_result.sv
exec_unit.sv
tb_exec_unit.sv

//--- run_sim.sh
#!/bin/sh
# Builds the execute stage testbench with Verilator and runs it from the project root
# The run counts as passed only when the pass line shows up in the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --timescale 1ns/1ns --top-module tb_exec_unit -f src.f
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

./obj_dir/Vtb_exec_unit > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^RESULT: PASS$" "$LOG"; then
    exit 0
fi
echo "Pass line not found in $LOG"
exit 1
